/* list.f */
+incdir+include
design/soc_mem_pkg.sv
design/ram_dp_be.sv
design/ram_sp_be.sv
design/sram.sv
design/boot_ctrl.sv
design/soc_mem.sv
sim/soc_mem_checker.sv
sim/soc_mem_tb.sv

/* sim/soc_mem_tb.sv */
`timescale 1ns/10ps

`include "soc_mem_cfg.svh"

module soc_mem_tb;
   import soc_mem_pkg::*;

   localparam int data_w      = `soc_data_w;
   localparam int sram_addr_w = `soc_sram_addr_w;
   localparam int boot_words  = `soc_boot_words;
   localparam int addr_w      = sram_addr_w - 2;
   localparam int lanes       = data_w / byte_w;
   localparam int table_len   = boot_words + 19;
   localparam int cycle_limit = 2 * (boot_words * 4 + table_len + 20);

   localparam int p_idle  = 0;
   localparam int p_fetch = 1;
   localparam int p_data  = 2;

   typedef struct {
      int                port;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] wdata;
      logic [lanes-1:0]  strb;     // zero is a read
      bit                coll;     // fetch in the same cycle
      logic [addr_w-1:0] faddr;    // address of that fetch
      logic [data_w-1:0] exp_d_sp;
      logic [data_w-1:0] exp_d_dp;
      logic [data_w-1:0] exp_f_sp;
      logic [data_w-1:0] exp_f_dp;
   } entry_t;

   logic              clk_i;
   logic              rst_i;
   logic              boot_valid;
   logic [byte_w-1:0] boot_byte;
   logic              fetch_avalid;
   logic [addr_w-1:0] fetch_addr;
   logic              d_avalid;
   logic [addr_w-1:0] d_addr;
   logic [data_w-1:0] d_wdata;
   logic [lanes-1:0]  d_wstrb;
   logic              boot_done;
   logic [data_w-1:0] fetch_rdata;
   logic              fetch_rvalid;
   logic [data_w-1:0] d_rdata;
   logic              d_rvalid;
   logic              dp_boot_done;
   logic [data_w-1:0] dp_fetch_rdata;
   logic              dp_fetch_rvalid;
   logic [data_w-1:0] dp_d_rdata;
   logic              dp_d_rvalid;

   entry_t            tbl [table_len];
   int                n_entries;
   logic [data_w-1:0] boot_img [boot_words];
   logic [data_w-1:0] model_sp [2**addr_w]; // single-port view, collided writes dropped
   logic [data_w-1:0] model_dp [2**addr_w];
   int                errors;
   int                checks;
   int                cycles;

   soc_mem #(
      .data_w      (data_w),
      .sram_addr_w (sram_addr_w),
      .boot_words  (boot_words),
      .use_spram   (1'b1)
   ) dut (
      .clk_i (clk_i), .rst_i (rst_i),
      .boot_valid (boot_valid), .boot_byte (boot_byte), .boot_done (boot_done),
      .fetch_avalid (fetch_avalid), .fetch_addr (fetch_addr),
      .fetch_rdata (fetch_rdata), .fetch_rvalid (fetch_rvalid),
      .d_avalid (d_avalid), .d_addr (d_addr), .d_wdata (d_wdata), .d_wstrb (d_wstrb),
      .d_rdata (d_rdata), .d_rvalid (d_rvalid)
   );

   soc_mem #(
      .data_w      (data_w),
      .sram_addr_w (sram_addr_w),
      .boot_words  (boot_words),
      .use_spram   (1'b0)
   ) dut_dp (
      .clk_i (clk_i), .rst_i (rst_i),
      .boot_valid (boot_valid), .boot_byte (boot_byte), .boot_done (dp_boot_done),
      .fetch_avalid (fetch_avalid), .fetch_addr (fetch_addr),
      .fetch_rdata (dp_fetch_rdata), .fetch_rvalid (dp_fetch_rvalid),
      .d_avalid (d_avalid), .d_addr (d_addr), .d_wdata (d_wdata), .d_wstrb (d_wstrb),
      .d_rdata (dp_d_rdata), .d_rvalid (dp_d_rvalid)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: run still going after %0d cycles", cycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // reference model and table
   ////////////////////////////////////////

   function automatic logic [data_w-1:0] merge_lanes(input logic [data_w-1:0] old_w,
                                                     input logic [data_w-1:0] new_w,
                                                     input logic [lanes-1:0]  strb);
      logic [data_w-1:0] res;
      res = old_w;
      for (int i = 0; i < lanes; i++) begin
         if (strb[i]) begin
            res[i*byte_w +: byte_w] = new_w[i*byte_w +: byte_w];
         end
      end
      return res;
   endfunction

   task automatic add_entry(input int port, input int addr, input logic [data_w-1:0] wdata,
                            input logic [lanes-1:0] strb, input bit coll, input int faddr);
      entry_t e;
      e.port  = port;
      e.addr  = addr_w'(addr);
      e.wdata = wdata;
      e.strb  = strb;
      e.coll  = coll;
      e.faddr = addr_w'(faddr);
      // answers carry the word from before this cycle's write
      e.exp_d_sp = coll ? model_sp[e.faddr] : model_sp[e.addr]; // loser sees the fetch word
      e.exp_d_dp = model_dp[e.addr];
      e.exp_f_sp = coll ? model_sp[e.faddr] : model_sp[e.addr];
      e.exp_f_dp = coll ? model_dp[e.faddr] : model_dp[e.addr];
      if (port == p_data) begin
         if (!coll) begin
            model_sp[e.addr] = merge_lanes(model_sp[e.addr], wdata, strb);
         end
         model_dp[e.addr] = merge_lanes(model_dp[e.addr], wdata, strb);
      end
      if (n_entries < table_len) begin
         tbl[n_entries] = e;
      end
      n_entries++;
   endtask

   task automatic build_table();
      for (int w = 0; w < boot_words; w++) begin
         boot_img[w] = data_w'($urandom);
         model_sp[w] = boot_img[w];
         model_dp[w] = boot_img[w];
      end
      n_entries = 0;
      for (int w = 0; w < boot_words; w++) begin
         add_entry(p_fetch, w, '0, '0, 1'b0, 0); // whole boot image back to back
      end
      add_entry(p_data, 3, '0, 4'b0000, 1'b0, 0);
      add_entry(p_data, 3, data_w'($urandom), 4'b0101, 1'b0, 0);
      add_entry(p_data, 3, '0, 4'b0000, 1'b0, 0);
      add_entry(p_fetch, 3, '0, '0, 1'b0, 0);
      add_entry(p_data, 5, data_w'($urandom), 4'b1000, 1'b0, 0);
      add_entry(p_data, 5, data_w'($urandom), 4'b0010, 1'b0, 0);
      add_entry(p_fetch, 5, '0, '0, 1'b0, 0);
      add_entry(p_data, 5, '0, 4'b0000, 1'b0, 0);
      add_entry(p_idle, 0, '0, '0, 1'b0, 0);
      add_entry(p_data, 7, '0, 4'b0000, 1'b0, 0);
      add_entry(p_fetch, 8, '0, '0, 1'b0, 0);
      add_entry(p_data, 9, '0, 4'b0000, 1'b0, 0);
      add_entry(p_fetch, 10, '0, '0, 1'b0, 0);
      ////////////////////////////////////////
      // collisions
      ////////////////////////////////////////
      add_entry(p_data, 12, data_w'($urandom), 4'b1111, 1'b1, 2);
      add_entry(p_data, 6, '0, 4'b0000, 1'b1, 1);
      add_entry(p_data, 12, '0, 4'b0000, 1'b0, 0);
      add_entry(p_fetch, 12, '0, '0, 1'b0, 0);
      add_entry(p_data, 13, data_w'($urandom), 4'b0011, 1'b1, 13);
      add_entry(p_data, 13, '0, 4'b0000, 1'b0, 0);
      if (n_entries != table_len) begin
         errors++;
         $display("stimulus table holds %0d entries instead of %0d", n_entries, table_len);
      end
   endtask

   ////////////////////////////////////////
   // drive and check
   ////////////////////////////////////////

   task automatic check_value(input string name, input logic [data_w-1:0] got,
                              input logic [data_w-1:0] exp);
      checks++;
      assert (got === exp)
      else begin
         errors++;
         $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      check_value(name, data_w'(got), data_w'(exp));
   endtask

   task automatic drive_entry(input entry_t e);
      fetch_avalid <= (e.port == p_fetch) || e.coll;
      fetch_addr   <= e.coll ? e.faddr : e.addr;
      d_avalid     <= (e.port == p_data);
      d_addr       <= e.addr;
      d_wdata      <= e.wdata;
      d_wstrb      <= e.strb;
   endtask

   task automatic check_response(input entry_t e);
      logic f_on;
      logic d_on;
      f_on = (e.port == p_fetch) || e.coll;
      d_on = (e.port == p_data);
      check_flag("dut.fetch_rvalid", fetch_rvalid, f_on);
      check_flag("dut_dp.fetch_rvalid", dp_fetch_rvalid, f_on);
      check_flag("dut.d_rvalid", d_rvalid, d_on);
      check_flag("dut_dp.d_rvalid", dp_d_rvalid, d_on);
      if (f_on) begin
         check_value("dut.fetch_rdata", fetch_rdata, e.exp_f_sp);
         check_value("dut_dp.fetch_rdata", dp_fetch_rdata, e.exp_f_dp);
      end
      if (d_on) begin
         check_value("dut.d_rdata", d_rdata, e.exp_d_sp);
         check_value("dut_dp.d_rdata", dp_d_rdata, e.exp_d_dp);
      end
   endtask

   initial begin
      entry_t idle;
      int     asrt_fails;
      void'($urandom(81862));
      rst_i        = 1'b1;
      boot_valid   = 1'b0;
      boot_byte    = '0;
      fetch_avalid = 1'b0;
      fetch_addr   = '0;
      d_avalid     = 1'b0;
      d_addr       = '0;
      d_wdata      = '0;
      d_wstrb      = '0;
      idle         = '{default: '0};
      idle.port    = p_idle;
      build_table();

      @(negedge clk_i);
      check_flag("dut.boot_done", boot_done, 1'b0);
      check_flag("dut.fetch_rvalid", fetch_rvalid, 1'b0);
      check_flag("dut.d_rvalid", d_rvalid, 1'b0);
      check_flag("dut_dp.boot_done", dp_boot_done, 1'b0);
      check_flag("dut_dp.fetch_rvalid", dp_fetch_rvalid, 1'b0);
      check_flag("dut_dp.d_rvalid", dp_d_rvalid, 1'b0);
      @(posedge clk_i);
      rst_i <= 1'b0;

      // boot stream with stray fetches that must be dropped
      for (int b = 0; b < boot_words * lanes; b++) begin
         @(posedge clk_i);
         boot_valid   <= 1'b1;
         boot_byte    <= boot_img[b / lanes][(b % lanes) * byte_w +: byte_w];
         fetch_avalid <= 1'($urandom_range(1, 0));
         fetch_addr   <= addr_w'($urandom);
         @(negedge clk_i);
         check_flag("dut.fetch_rvalid", fetch_rvalid, 1'b0);
         check_flag("dut_dp.fetch_rvalid", dp_fetch_rvalid, 1'b0);
      end
      @(posedge clk_i);
      boot_valid   <= 1'b0;
      fetch_avalid <= 1'b0;
      @(negedge clk_i);
      while (!(boot_done && dp_boot_done)) begin
         check_flag("dut.fetch_rvalid", fetch_rvalid, 1'b0);
         check_flag("dut_dp.fetch_rvalid", dp_fetch_rvalid, 1'b0);
         @(negedge clk_i);
      end

      for (int i = 0; i <= table_len; i++) begin
         @(posedge clk_i);
         if (i < table_len) begin
            drive_entry(tbl[i]);
         end else begin
            drive_entry(idle);
         end
         @(negedge clk_i);
         if (i > 0) begin
            check_response(tbl[i-1]); // driven one edge before this one
         end
      end

      @(posedge clk_i);
      @(negedge clk_i);
      asrt_fails = dut.u_sram.u_checker.fails + dut_dp.u_sram.u_checker.fails;
      $display("checks %0d  value errors %0d  assertion failures %0d",
               checks, errors, asrt_fails);
      if ((errors == 0) && (asrt_fails == 0)) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* sim/soc_mem_checker.sv */
`timescale 1ns/10ps

module soc_mem_checker (
   input logic clk_i,
   input logic rst_i,
   input logic i_avalid,
   input logic i_rvalid,
   input logic d_avalid,
   input logic d_rvalid
);

   int fails; // read by the testbench at the end of the run

   ////////////////////////////////////////
   // one cycle request to response
   ////////////////////////////////////////

   a_i_resp : assert property (@(posedge clk_i) disable iff (rst_i) i_avalid |=> i_rvalid)
      else begin
         fails++;
         $error("instruction request not answered one cycle later");
      end

   a_i_spur : assert property (@(posedge clk_i) disable iff (rst_i) !i_avalid |=> !i_rvalid)
      else begin
         fails++;
         $error("instruction rvalid without a request");
      end

   a_d_resp : assert property (@(posedge clk_i) disable iff (rst_i) d_avalid |=> d_rvalid)
      else begin
         fails++;
         $error("data request not answered one cycle later");
      end

   a_d_spur : assert property (@(posedge clk_i) disable iff (rst_i) !d_avalid |=> !d_rvalid)
      else begin
         fails++;
         $error("data rvalid without a request");
      end

   // first cycle out of reset is quiet
   a_rst_quiet : assert property (@(posedge clk_i) $fell(rst_i) |-> !i_rvalid && !d_rvalid)
      else begin
         fails++;
         $error("rvalid high right after reset");
      end

endmodule

bind sram soc_mem_checker u_checker (
   .clk_i    (clk_i),
   .rst_i    (rst_i),
   .i_avalid (i_avalid),
   .i_rvalid (i_rvalid),
   .d_avalid (d_avalid),
   .d_rvalid (d_rvalid)
);

/* design/soc_mem.sv */
`timescale 1ns/10ps

`include "soc_mem_cfg.svh"

module soc_mem #(
   parameter int data_w      = `soc_data_w,
   parameter int sram_addr_w = `soc_sram_addr_w,
   parameter int boot_words  = `soc_boot_words,
   parameter bit use_spram   = 1'b0
) (
   input  logic                                  clk_i,
   input  logic                                  rst_i,

   // boot stream
   input  logic                                  boot_valid,
   input  logic [soc_mem_pkg::byte_w-1:0]        boot_byte,
   output logic                                  boot_done,

   // fetch port
   input  logic                                  fetch_avalid,
   input  logic [sram_addr_w-3:0]                fetch_addr,
   output logic [data_w-1:0]                     fetch_rdata,
   output logic                                  fetch_rvalid,

   // data port
   input  logic                                  d_avalid,
   input  logic [sram_addr_w-3:0]                d_addr,
   input  logic [data_w-1:0]                     d_wdata,
   input  logic [data_w/soc_mem_pkg::byte_w-1:0] d_wstrb,
   output logic [data_w-1:0]                     d_rdata,
   output logic                                  d_rvalid
);
   import soc_mem_pkg::*;

   logic                     i_avalid;
   logic [sram_addr_w-3:0]   i_addr;
   logic [data_w-1:0]        i_wdata;
   logic [data_w/byte_w-1:0] i_wstrb;
   logic [data_w-1:0]        i_rdata;
   logic                     i_rvalid;

   ////////////////////////////////////////
   // boot loader and fetch path
   ////////////////////////////////////////

   boot_ctrl #(
      .data_w      (data_w),
      .sram_addr_w (sram_addr_w),
      .boot_words  (boot_words)
   ) u_boot_ctrl (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .boot_valid   (boot_valid),
      .boot_byte    (boot_byte),
      .fetch_avalid (fetch_avalid),
      .fetch_addr   (fetch_addr),
      .fetch_rdata  (fetch_rdata),
      .fetch_rvalid (fetch_rvalid),
      .i_avalid     (i_avalid),
      .i_addr       (i_addr),
      .i_wdata      (i_wdata),
      .i_wstrb      (i_wstrb),
      .i_rdata      (i_rdata),
      .i_rvalid     (i_rvalid),
      .boot_done    (boot_done)
   );

   ////////////////////////////////////////
   // shared memory
   ////////////////////////////////////////

   sram #(
      .data_w      (data_w),
      .sram_addr_w (sram_addr_w),
      .use_spram   (use_spram)
   ) u_sram (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .i_avalid (i_avalid),
      .i_addr   (i_addr),
      .i_wdata  (i_wdata),
      .i_wstrb  (i_wstrb),
      .i_rdata  (i_rdata),
      .i_rvalid (i_rvalid),
      .d_avalid (d_avalid), // data bus goes straight through
      .d_addr   (d_addr),
      .d_wdata  (d_wdata),
      .d_wstrb  (d_wstrb),
      .d_rdata  (d_rdata),
      .d_rvalid (d_rvalid)
   );

endmodule

/* design/boot_ctrl.sv */
`timescale 1ns/10ps

`include "soc_mem_cfg.svh"

module boot_ctrl #(
   parameter int data_w      = `soc_data_w,
   parameter int sram_addr_w = `soc_sram_addr_w,
   parameter int boot_words  = `soc_boot_words
) (
   input  logic                                  clk_i,
   input  logic                                  rst_i,

   // boot stream
   input  logic                                  boot_valid,
   input  logic [soc_mem_pkg::byte_w-1:0]        boot_byte,

   // fetch port
   input  logic                                  fetch_avalid,
   input  logic [sram_addr_w-3:0]                fetch_addr,
   output logic [data_w-1:0]                     fetch_rdata,
   output logic                                  fetch_rvalid,

   // instruction bus to sram
   output logic                                  i_avalid,
   output logic [sram_addr_w-3:0]                i_addr,
   output logic [data_w-1:0]                     i_wdata,
   output logic [data_w/soc_mem_pkg::byte_w-1:0] i_wstrb,
   input  logic [data_w-1:0]                     i_rdata,
   input  logic                                  i_rvalid,

   output logic                                  boot_done
);
   import soc_mem_pkg::*;

   localparam int lanes  = data_w / byte_w;
   localparam int lane_w = (lanes > 1) ? $clog2(lanes) : 1;
   localparam int addr_w = sram_addr_w - 2;
   localparam int cnt_w  = $clog2(boot_words + 1);

   boot_state_e       state;
   logic [lane_w-1:0] lane_cnt;
   logic [data_w-1:0] word_sr;
   logic [cnt_w-1:0]  word_cnt; // words written so far
   logic              wr_q;     // boot write strobe
   logic              fetch_q;  // last request was a fetch
   logic              take_byte;
   logic              last_lane;

   assign take_byte = boot_valid && (state == boot_load) &&
                      (word_cnt != cnt_w'(boot_words));
   assign last_lane = (lane_cnt == lane_w'(lanes - 1));

   ////////////////////////////////////////
   // word assembly
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (take_byte) begin
         word_sr <= {boot_byte, word_sr[data_w-1:byte_w]}; // first byte ends up lsb
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state    <= boot_load;
         lane_cnt <= '0;
         word_cnt <= '0;
         wr_q     <= 1'b0;
         fetch_q  <= 1'b0;
      end else begin
         wr_q    <= take_byte && last_lane;
         fetch_q <= (state == boot_run) && fetch_avalid;
         if (take_byte) begin
            lane_cnt <= last_lane ? '0 : lane_cnt + 1'b1;
         end
         if (wr_q) begin
            word_cnt <= word_cnt + 1'b1;
         end
         // hand over once the last write has been answered
         if ((state == boot_load) && i_rvalid && (word_cnt == cnt_w'(boot_words))) begin
            state <= boot_run;
         end
      end
   end

   ////////////////////////////////////////
   // instruction bus
   ////////////////////////////////////////

   always_comb begin
      case (state)
         boot_load: begin
            i_avalid = wr_q; // fetches dropped while loading
            i_addr   = addr_w'(word_cnt);
            i_wstrb  = '1;
         end
         default: begin
            i_avalid = fetch_avalid;
            i_addr   = fetch_addr;
            i_wstrb  = '0;
         end
      endcase
   end

   assign i_wdata      = word_sr;
   assign fetch_rdata  = i_rdata;
   assign fetch_rvalid = i_rvalid & fetch_q; // boot write responses stay here
   assign boot_done    = (state == boot_run);

endmodule

/* design/sram.sv */
`timescale 1ns/10ps

`include "soc_mem_cfg.svh"

module sram #(
   parameter int data_w      = `soc_data_w,
   parameter int sram_addr_w = `soc_sram_addr_w,
   parameter bit use_spram   = 1'b0
) (
   input  logic                                  clk_i,
   input  logic                                  rst_i,

   // instruction bus
   input  logic                                  i_avalid,
   input  logic [sram_addr_w-3:0]                i_addr,
   input  logic [data_w-1:0]                     i_wdata,
   input  logic [data_w/soc_mem_pkg::byte_w-1:0] i_wstrb, // boot writes
   output logic [data_w-1:0]                     i_rdata,
   output logic                                  i_rvalid,

   // data bus
   input  logic                                  d_avalid,
   input  logic [sram_addr_w-3:0]                d_addr,
   input  logic [data_w-1:0]                     d_wdata,
   input  logic [data_w/soc_mem_pkg::byte_w-1:0] d_wstrb,
   output logic [data_w-1:0]                     d_rdata,
   output logic                                  d_rvalid
);
   import soc_mem_pkg::*;

   localparam int lanes = data_w / byte_w;

   ////////////////////////////////////////
   // memory build
   ////////////////////////////////////////

   generate
      if (use_spram) begin : g_sp
         logic                   en;
         logic [sram_addr_w-3:0] addr;
         logic [data_w-1:0]      wdata;
         logic [lanes-1:0]       wstrb;
         logic [data_w-1:0]      rdata;

         assign en    = i_avalid | d_avalid;
         assign addr  = i_avalid ? i_addr  : d_addr; // instruction bus first
         assign wdata = i_avalid ? i_wdata : d_wdata;
         assign wstrb = i_avalid ? i_wstrb : d_wstrb; // losing data write is dropped

         ram_sp_be #(
            .addr_w (sram_addr_w - 2),
            .data_w (data_w)
         ) u_ram (
            .clk_i (clk_i),
            .en    (en),
            .addr  (addr),
            .we    (wstrb),
            .din   (wdata),
            .dout  (rdata)
         );

         assign i_rdata = rdata;
         assign d_rdata = rdata; // collided data request sees the fetch word
      end else begin : g_dp
         ram_dp_be #(
            .addr_w (sram_addr_w - 2),
            .data_w (data_w)
         ) u_ram (
            .clk_i  (clk_i),
            .en_a   (d_avalid),
            .addr_a (d_addr),
            .we_a   (d_wstrb),
            .din_a  (d_wdata),
            .dout_a (d_rdata),
            .en_b   (i_avalid), // instruction side wins a shared byte
            .addr_b (i_addr),
            .we_b   (i_wstrb),
            .din_b  (i_wdata),
            .dout_b (i_rdata)
         );
      end
   endgenerate

   ////////////////////////////////////////
   // responses
   ////////////////////////////////////////

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         i_rvalid <= 1'b0;
         d_rvalid <= 1'b0;
      end else begin
         i_rvalid <= i_avalid; // every request answered, writes too
         d_rvalid <= d_avalid;
      end
   end

endmodule

/* design/ram_sp_be.sv */
`timescale 1ns/10ps

`include "soc_mem_cfg.svh"

module ram_sp_be #(
   parameter int addr_w = `soc_sram_addr_w - 2,
   parameter int data_w = `soc_data_w
) (
   input  logic                                  clk_i,
   input  logic                                  en,
   input  logic [addr_w-1:0]                     addr,
   input  logic [data_w/soc_mem_pkg::byte_w-1:0] we,
   input  logic [data_w-1:0]                     din,
   output logic [data_w-1:0]                     dout
);
   import soc_mem_pkg::*;

   localparam int lanes = data_w / byte_w;
   localparam int depth = 2 ** addr_w;

   logic [data_w-1:0] mem [depth];

   ////////////////////////////////////////
   // array and registered read
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (en) begin
         dout <= mem[addr]; // read before write
         for (int i = 0; i < lanes; i++) begin
            if (we[i]) begin
               mem[addr][i*byte_w +: byte_w] <= din[i*byte_w +: byte_w];
            end
         end
      end
   end

endmodule

/* design/ram_dp_be.sv */
`timescale 1ns/10ps

`include "soc_mem_cfg.svh"

module ram_dp_be #(
   parameter int addr_w = `soc_sram_addr_w - 2,
   parameter int data_w = `soc_data_w
) (
   input  logic                                  clk_i,

   // port a
   input  logic                                  en_a,
   input  logic [addr_w-1:0]                     addr_a,
   input  logic [data_w/soc_mem_pkg::byte_w-1:0] we_a,
   input  logic [data_w-1:0]                     din_a,
   output logic [data_w-1:0]                     dout_a,

   // port b
   input  logic                                  en_b,
   input  logic [addr_w-1:0]                     addr_b,
   input  logic [data_w/soc_mem_pkg::byte_w-1:0] we_b,
   input  logic [data_w-1:0]                     din_b,
   output logic [data_w-1:0]                     dout_b
);
   import soc_mem_pkg::*;

   localparam int lanes = data_w / byte_w;
   localparam int depth = 2 ** addr_w;

   logic [data_w-1:0] mem [depth];

   ////////////////////////////////////////
   // array and registered reads
   ////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (en_a) begin
         dout_a <= mem[addr_a]; // word as it was before this edge
         for (int i = 0; i < lanes; i++) begin
            if (we_a[i]) begin
               mem[addr_a][i*byte_w +: byte_w] <= din_a[i*byte_w +: byte_w];
            end
         end
      end

      // port b comes last so it wins a shared byte
      if (en_b) begin
         dout_b <= mem[addr_b];
         for (int i = 0; i < lanes; i++) begin
            if (we_b[i]) begin
               mem[addr_b][i*byte_w +: byte_w] <= din_b[i*byte_w +: byte_w];
            end
         end
      end
   end

endmodule

/* design/soc_mem_pkg.sv */
package soc_mem_pkg;

   ////////////////////////////////////////
   // bus geometry
   ////////////////////////////////////////

   localparam int byte_w = 8; // one write strobe per lane

   ////////////////////////////////////////
   // boot controller
   ////////////////////////////////////////

   typedef enum logic [0:0] {
      boot_load = 1'b0, // filling memory from the byte stream
      boot_run  = 1'b1  // fetch port owns the instruction bus
   } boot_state_e;

endpackage

/* include/soc_mem_cfg.svh */
`ifndef soc_mem_cfg_svh
`define soc_mem_cfg_svh

////////////////////////////////////////
// memory subsystem defaults
////////////////////////////////////////

// bus word width in bits
`define soc_data_w 32

// byte address width of the sram, word address is 2 bits narrower
`define soc_sram_addr_w 12

// words loaded from the boot stream after reset
`define soc_boot_words 16

`endif
